// File: common/wb_pkg.sv
// Wishbone bus definitions
package wb_pkg;

	localparam int WB_ADDR_WIDTH = 32;
	localparam int WB_DATA_WIDTH = 32;
	localparam int WB_SEL_WIDTH  = WB_DATA_WIDTH / 8;

	// Number of masters on the shared bus
	localparam int N_MASTERS = 4;

	typedef logic [WB_ADDR_WIDTH-1:0] wb_addr_t;
	typedef logic [WB_DATA_WIDTH-1:0] wb_data_t;
	typedef logic [WB_SEL_WIDTH-1:0]  wb_sel_t;
	typedef logic [1:0]               master_id_t;

	// One address word, seen as a raw value for decode
	// or split into fields for word addressing
	typedef union packed {
		wb_addr_t raw;
		struct packed {
			logic [19:0] region;
			logic [9:0]  word_index;
			logic [1:0]  byte_offset;
		} fields;
	} wb_addr_u;

endpackage

// File: common/wb_if.sv
// Wishbone classic bus
`timescale 1ns/1ps

interface wb_if;
	import wb_pkg::*;

	// Request side
	wb_addr_t adr;
	wb_data_t dat_w;
	wb_sel_t  sel;
	logic     we;
	logic     cyc;
	logic     stb;

	// Response side
	wb_data_t dat_r;
	logic     ack;
	logic     err;

	modport master (
		output adr,
		output dat_w,
		output sel,
		output we,
		output cyc,
		output stb,
		input  dat_r,
		input  ack,
		input  err
	);

	modport slave (
		input  adr,
		input  dat_w,
		input  sel,
		input  we,
		input  cyc,
		input  stb,
		output dat_r,
		output ack,
		output err
	);

endinterface

// File: wb_interconnect/wb_rr_arbiter.sv
// Round-robin arbiter with held grant
`timescale 1ns/1ps

module wb_rr_arbiter #(
	parameter int N_REQ = 4
) (
	input  logic                 clk,
	input  logic                 rstn,
	input  logic [N_REQ-1:0]     req_i,
	output logic                 gnt_o,
	output logic [(N_REQ > 1 ? $clog2(N_REQ) : 1)-1:0] gnt_id_o
);
	localparam int ID_W = (N_REQ > 1) ? $clog2(N_REQ) : 1;

	logic [N_REQ-1:0] gnt_q;
	logic [N_REQ-1:0] last_q;
	logic [ID_W-1:0]  gnt_id_q;
	logic [N_REQ-1:0] above_last;
	logic [N_REQ-1:0] masked_req;
	logic [N_REQ-1:0] masked_pick;
	logic [N_REQ-1:0] lowest_pick;
	logic [N_REQ-1:0] pick;

	function automatic logic [ID_W-1:0] onehot_to_id(input logic [N_REQ-1:0] vec);
		logic [ID_W-1:0] id;
		id = '0;
		for (int i = 0; i < N_REQ; i++) begin
			if (vec[i]) begin
				id = id | ID_W'(i);
			end
		end
		return id;
	endfunction

	// Bits strictly above the last winner
	always_comb begin
		above_last = '0;
		for (int i = 1; i < N_REQ; i++) begin
			above_last[i] = above_last[i-1] | last_q[i-1];
		end
	end

	assign masked_req = req_i & above_last;

	// x & -x keeps the lowest set bit
	assign masked_pick = masked_req & (~masked_req + 1'b1);
	assign lowest_pick = req_i & (~req_i + 1'b1);
	assign pick = (|masked_req) ? masked_pick : lowest_pick;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			gnt_q    <= '0;
			last_q   <= '0;
			gnt_id_q <= '0;
		end else if (gnt_q == '0) begin
			if (|pick) begin
				gnt_q    <= pick;
				last_q   <= pick;
				gnt_id_q <= onehot_to_id(pick);
			end
		end else if ((gnt_q & req_i) == '0) begin
			// Winner released, free the target
			gnt_q <= '0;
		end
	end

	assign gnt_o    = |gnt_q;
	assign gnt_id_o = gnt_id_q;

	a_gnt_onehot: assert property (@(posedge clk) disable iff (!rstn)
		$onehot0(gnt_q));

endmodule

// File: wb_interconnect/wb_interconnect_4x1.sv
// Four-master Wishbone interconnect
`timescale 1ns/1ps

module wb_interconnect_4x1 #(
	parameter wb_pkg::wb_addr_t SLAVE0_ADDR_BASE  = 32'h0000_0000,
	parameter wb_pkg::wb_addr_t SLAVE0_ADDR_LIMIT = 32'h0000_0FFF
) (
	input  logic                           clk,
	input  logic                           rstn,
	input  wb_pkg::wb_addr_t               m_adr_i   [wb_pkg::N_MASTERS],
	input  wb_pkg::wb_data_t               m_dat_w_i [wb_pkg::N_MASTERS],
	input  wb_pkg::wb_sel_t                m_sel_i   [wb_pkg::N_MASTERS],
	input  logic [wb_pkg::N_MASTERS-1:0]   m_we_i,
	input  logic [wb_pkg::N_MASTERS-1:0]   m_cyc_i,
	input  logic [wb_pkg::N_MASTERS-1:0]   m_stb_i,
	output wb_pkg::wb_data_t               m_dat_r_o [wb_pkg::N_MASTERS],
	output logic [wb_pkg::N_MASTERS-1:0]   m_ack_o,
	output logic [wb_pkg::N_MASTERS-1:0]   m_err_o,
	wb_if.master                           s0
);
	import wb_pkg::*;

	// Target 0 is the memory, target 1 the decode-fail responder
	localparam int N_TARGETS = 2;

	wb_if serr_bus ();

	wb_addr_u         m_adr_u [N_MASTERS];
	logic [N_MASTERS-1:0] m_in_window;
	logic [N_MASTERS-1:0] m_wait_q;
	logic [N_MASTERS-1:0] m_tgt_q;
	logic [N_MASTERS-1:0] m_hit;

	logic [N_MASTERS-1:0] tgt_req [N_TARGETS];
	logic [N_TARGETS-1:0] tgt_gnt;
	master_id_t           tgt_gnt_id [N_TARGETS];
	logic [N_TARGETS-1:0] tgt_active;

	wb_addr_t t_adr   [N_TARGETS];
	wb_data_t t_dat_w [N_TARGETS];
	wb_sel_t  t_sel   [N_TARGETS];
	logic [N_TARGETS-1:0] t_we;
	logic [N_TARGETS-1:0] t_cyc;
	logic [N_TARGETS-1:0] t_stb;
	wb_data_t t_dat_r [N_TARGETS];
	logic [N_TARGETS-1:0] t_ack;
	logic [N_TARGETS-1:0] t_err;

	logic serr_q;

	for (genvar m = 0; m < N_MASTERS; m++) begin : g_master
		assign m_adr_u[m].raw = m_adr_i[m];
		assign m_in_window[m] = (m_adr_u[m].raw >= SLAVE0_ADDR_BASE) &&
			(m_adr_u[m].raw <= SLAVE0_ADDR_LIMIT);

		// Idle/wait tracker, target latched on the first CYC and STB edge
		always_ff @(posedge clk) begin
			if (!rstn) begin
				m_wait_q[m] <= 1'b0;
				m_tgt_q[m]  <= 1'b0;
			end else if (!m_wait_q[m]) begin
				if (m_cyc_i[m] && m_stb_i[m]) begin
					m_wait_q[m] <= 1'b1;
					m_tgt_q[m]  <= !m_in_window[m];
				end
			end else if (m_ack_o[m] || m_err_o[m]) begin
				m_wait_q[m] <= 1'b0;
			end
		end

		// Responses only reach the granted master while it waits
		assign m_hit[m] = m_wait_q[m] && tgt_gnt[m_tgt_q[m]] &&
			(tgt_gnt_id[m_tgt_q[m]] == master_id_t'(m));
		assign m_ack_o[m]   = m_hit[m] && t_ack[m_tgt_q[m]];
		assign m_err_o[m]   = m_hit[m] && t_err[m_tgt_q[m]];
		assign m_dat_r_o[m] = m_hit[m] ? t_dat_r[m_tgt_q[m]] : '0;
	end

	assign tgt_req[0] = m_wait_q & ~m_tgt_q;
	assign tgt_req[1] = m_wait_q & m_tgt_q;

	for (genvar t = 0; t < N_TARGETS; t++) begin : g_arb
		wb_rr_arbiter #(
			.N_REQ (N_MASTERS)
		) u_arb (
			.clk      (clk),
			.rstn     (rstn),
			.req_i    (tgt_req[t]),
			.gnt_o    (tgt_gnt[t]),
			.gnt_id_o (tgt_gnt_id[t])
		);
	end

	// Forward the granted master only while it still waits on this target
	always_comb begin
		for (int t = 0; t < N_TARGETS; t++) begin
			tgt_active[t] = tgt_gnt[t] && m_wait_q[tgt_gnt_id[t]] &&
				(m_tgt_q[tgt_gnt_id[t]] == 1'(t));
			t_adr[t]   = tgt_active[t] ? m_adr_i[tgt_gnt_id[t]] : '0;
			t_dat_w[t] = tgt_active[t] ? m_dat_w_i[tgt_gnt_id[t]] : '0;
			t_sel[t]   = tgt_active[t] ? m_sel_i[tgt_gnt_id[t]] : '0;
			t_we[t]    = tgt_active[t] && m_we_i[tgt_gnt_id[t]];
			t_cyc[t]   = tgt_active[t] && m_cyc_i[tgt_gnt_id[t]];
			t_stb[t]   = tgt_active[t] && m_stb_i[tgt_gnt_id[t]];
		end
	end

	assign s0.adr   = t_adr[0];
	assign s0.dat_w = t_dat_w[0];
	assign s0.sel   = t_sel[0];
	assign s0.we    = t_we[0];
	assign s0.cyc   = t_cyc[0];
	assign s0.stb   = t_stb[0];
	assign t_dat_r[0] = s0.dat_r;
	assign t_ack[0]   = s0.ack;
	assign t_err[0]   = s0.err;

	assign serr_bus.adr   = t_adr[1];
	assign serr_bus.dat_w = t_dat_w[1];
	assign serr_bus.sel   = t_sel[1];
	assign serr_bus.we    = t_we[1];
	assign serr_bus.cyc   = t_cyc[1];
	assign serr_bus.stb   = t_stb[1];
	assign t_dat_r[1] = serr_bus.dat_r;
	assign t_ack[1]   = serr_bus.ack;
	assign t_err[1]   = serr_bus.err;

	// Decode-fail target, answers every access with ERR one edge later
	always_ff @(posedge clk) begin
		if (!rstn) begin
			serr_q <= 1'b0;
		end else begin
			serr_q <= serr_bus.cyc && serr_bus.stb && !serr_q;
		end
	end

	assign serr_bus.err   = serr_q;
	assign serr_bus.ack   = 1'b0;
	assign serr_bus.dat_r = '0;

	// Memory and error target must never answer the same master together
	a_ack_err_excl: assert property (@(posedge clk) disable iff (!rstn)
		(m_ack_o & m_err_o) == '0);

endmodule

// File: hdl/wb_sram_slave.sv
// Word memory Wishbone slave
`timescale 1ns/1ps

module wb_sram_slave #(
	parameter int MEM_WORDS = 1024
) (
	input logic clk,
	input logic rstn,
	wb_if.slave bus
);
	import wb_pkg::*;

	localparam int IDX_W = $clog2(MEM_WORDS);

	wb_data_t         mem [MEM_WORDS];
	wb_addr_u         addr_view;
	logic [IDX_W-1:0] mem_idx;
	logic             ack_q;
	logic             access;
	wb_data_t         rdata_q;

	assign addr_view = bus.adr;
	assign mem_idx   = addr_view.fields.word_index[IDX_W-1:0];

	// New access only while the previous ACK is low
	assign access = bus.cyc && bus.stb && !ack_q;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= access;
		end
	end

	always_ff @(posedge clk) begin
		if (access) begin
			if (bus.we) begin
				for (int b = 0; b < WB_SEL_WIDTH; b++) begin
					if (bus.sel[b]) begin
						mem[mem_idx][8*b +: 8] <= bus.dat_w[8*b +: 8];
					end
				end
				rdata_q <= '0;
			end else begin
				rdata_q <= mem[mem_idx];
			end
		end
	end

	assign bus.ack   = ack_q;
	assign bus.err   = 1'b0;
	assign bus.dat_r = ack_q ? rdata_q : '0;

	a_ack_after_stb: assert property (@(posedge clk) disable iff (!rstn)
		$rose(bus.ack) |-> $past(bus.stb));

endmodule

// File: hdl/wb_subsystem_top.sv
// Wishbone shared-bus subsystem
`timescale 1ns/1ps

module wb_subsystem_top #(
	parameter wb_pkg::wb_addr_t SLAVE0_ADDR_BASE  = 32'h0000_0000,
	parameter wb_pkg::wb_addr_t SLAVE0_ADDR_LIMIT = 32'h0000_0FFF,
	parameter int               MEM_WORDS         = 1024
) (
	input  logic                           clk,
	input  logic                           rstn,

	// Master request side, one entry per master
	input  wb_pkg::wb_addr_t               m_adr_i   [wb_pkg::N_MASTERS],
	input  wb_pkg::wb_data_t               m_dat_w_i [wb_pkg::N_MASTERS],
	input  wb_pkg::wb_sel_t                m_sel_i   [wb_pkg::N_MASTERS],
	input  logic [wb_pkg::N_MASTERS-1:0]   m_we_i,
	input  logic [wb_pkg::N_MASTERS-1:0]   m_cyc_i,
	input  logic [wb_pkg::N_MASTERS-1:0]   m_stb_i,

	// Master response side
	output wb_pkg::wb_data_t               m_dat_r_o [wb_pkg::N_MASTERS],
	output logic [wb_pkg::N_MASTERS-1:0]   m_ack_o,
	output logic [wb_pkg::N_MASTERS-1:0]   m_err_o
);

	// Interconnect to memory
	wb_if mem_bus ();

	wb_interconnect_4x1 #(
		.SLAVE0_ADDR_BASE  (SLAVE0_ADDR_BASE),
		.SLAVE0_ADDR_LIMIT (SLAVE0_ADDR_LIMIT)
	) u_interconnect (
		.clk       (clk),
		.rstn      (rstn),
		.m_adr_i   (m_adr_i),
		.m_dat_w_i (m_dat_w_i),
		.m_sel_i   (m_sel_i),
		.m_we_i    (m_we_i),
		.m_cyc_i   (m_cyc_i),
		.m_stb_i   (m_stb_i),
		.m_dat_r_o (m_dat_r_o),
		.m_ack_o   (m_ack_o),
		.m_err_o   (m_err_o),
		.s0        (mem_bus.master)
	);

	wb_sram_slave #(
		.MEM_WORDS (MEM_WORDS)
	) u_sram (
		.clk  (clk),
		.rstn (rstn),
		.bus  (mem_bus.slave)
	);

endmodule

// File: tb/tb_wb_subsystem.sv
// Wishbone subsystem testbench
`timescale 1ns/1ps

module tb_wb_subsystem;
	import wb_pkg::*;

	localparam int MAX_LINES = 64;
	localparam int TIMEOUT   = 100;

	logic                 clk = 1'b0;
	logic                 rstn;
	wb_addr_t             m_adr   [N_MASTERS];
	wb_data_t             m_dat_w [N_MASTERS];
	wb_sel_t              m_sel   [N_MASTERS];
	logic [N_MASTERS-1:0] m_we;
	logic [N_MASTERS-1:0] m_cyc;
	logic [N_MASTERS-1:0] m_stb;
	wb_data_t             m_dat_r [N_MASTERS];
	logic [N_MASTERS-1:0] m_ack;
	logic [N_MASTERS-1:0] m_err;

	// Stimulus entries per transfer
	logic [63:0] s_tag  [MAX_LINES];
	int          s_mid  [MAX_LINES];
	logic        s_we   [MAX_LINES];
	wb_addr_t    s_adr  [MAX_LINES];
	wb_data_t    s_wdat [MAX_LINES];
	wb_sel_t     s_sel  [MAX_LINES];
	logic        s_ack  [MAX_LINES];
	wb_data_t    s_rdat [MAX_LINES];
	int          n_lines;

	int         n_checks;
	int         n_mismatch;
	int         n_fail;
	int         last_winner;
	master_id_t exp_order [$];
	master_id_t got_order [$];

	wb_subsystem_top #(
		.SLAVE0_ADDR_BASE  (32'h0000_0000),
		.SLAVE0_ADDR_LIMIT (32'h0000_0FFF),
		.MEM_WORDS         (1024)
	) DUT (
		.clk       (clk),
		.rstn      (rstn),
		.m_adr_i   (m_adr),
		.m_dat_w_i (m_dat_w),
		.m_sel_i   (m_sel),
		.m_we_i    (m_we),
		.m_cyc_i   (m_cyc),
		.m_stb_i   (m_stb),
		.m_dat_r_o (m_dat_r),
		.m_ack_o   (m_ack),
		.m_err_o   (m_err)
	);

	always #2 clk = ~clk;

	task automatic check_data(input wb_data_t got, input wb_data_t exp, input string what);
		n_checks++;
		if (got !== exp) begin
			n_mismatch++;
			$display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_resp(input logic got_ack, input logic got_err,
		input logic exp_ack, input logic exp_err, input string what);
		n_checks++;
		if ({got_ack, got_err} !== {exp_ack, exp_err}) begin
			n_mismatch++;
			$display("mismatch at %0t: %s ack/err is %b%b, expected %b%b", $time, what,
				got_ack, got_err, exp_ack, exp_err);
		end
	endtask

	task automatic check_order(input master_id_t got, input master_id_t exp, input int pos);
		n_checks++;
		if (got !== exp) begin
			n_mismatch++;
			$display("mismatch at %0t: completion %0d is master %0d, expected master %0d",
				$time, pos, got, exp);
		end
	endtask

	task automatic check_idle_outputs();
		for (int m = 0; m < N_MASTERS; m++) begin
			check_resp(m_ack[m], m_err[m], 1'b0, 1'b0, $sformatf("master %0d idle", m));
			check_data(m_dat_r[m], '0, $sformatf("master %0d idle data", m));
		end
	endtask

	task automatic load_stimulus();
		int               fd;
		int               cnt;
		logic [8*128-1:0] line;
		logic [63:0]      resp;
		n_lines = 0;
		fd = $fopen("tb/wb_stimulus.txt", "r");
		if (fd == 0) begin
			n_fail++;
			$display("could not open the stimulus file tb/wb_stimulus.txt");
		end else begin
			while (n_lines < MAX_LINES && $fgets(line, fd) != 0) begin
				// Comment lines never parse into all eight columns
				cnt = $sscanf(line, "%s %d %d %h %h %h %s %h", s_tag[n_lines], s_mid[n_lines],
					s_we[n_lines], s_adr[n_lines], s_wdat[n_lines], s_sel[n_lines], resp,
					s_rdat[n_lines]);
				if (cnt == 8) begin
					s_ack[n_lines] = (resp == "ack");
					n_lines++;
				end
			end
			$fclose(fd);
			if (n_lines == 0) begin
				n_fail++;
				$display("the stimulus file tb/wb_stimulus.txt holds no transfers");
			end
		end
	endtask

	task automatic run_transfer(input int idx, input bit in_group);
		int       m;
		int       cycles;
		logic     got_ack;
		logic     got_err;
		wb_data_t got_dat;
		m = s_mid[idx];
		@(posedge clk);
		m_adr[m]   <= s_adr[idx];
		m_dat_w[m] <= s_wdat[idx];
		m_sel[m]   <= s_sel[idx];
		m_we[m]    <= s_we[idx];
		m_cyc[m]   <= 1'b1;
		m_stb[m]   <= 1'b1;
		got_ack = 1'b0;
		got_err = 1'b0;
		got_dat = '0;
		cycles  = 0;
		while (!got_ack && !got_err && cycles < TIMEOUT) begin
			@(negedge clk);
			got_ack = m_ack[m];
			got_err = m_err[m];
			got_dat = m_dat_r[m];
			cycles++;
		end
		if (!got_ack && !got_err) begin
			n_fail++;
			$display("master %0d got neither ACK nor ERR within %0d cycles for entry %0d",
				m, TIMEOUT, idx);
		end else begin
			if (in_group) begin
				got_order.push_back(master_id_t'(m));
			end
			check_resp(got_ack, got_err, s_ack[idx], !s_ack[idx],
				$sformatf("master %0d entry %0d", m, idx));
			check_data(got_dat, s_rdat[idx], $sformatf("master %0d entry %0d data", m, idx));
		end
		// Release on the strobe edge and expect the strobe to be gone
		@(posedge clk);
		m_cyc[m] <= 1'b0;
		m_stb[m] <= 1'b0;
		m_we[m]  <= 1'b0;
		@(negedge clk);
		check_resp(m_ack[m], m_err[m], 1'b0, 1'b0, $sformatf("master %0d after release", m));
	endtask

	task automatic run_master_lines(input int m, input int first, input int last);
		for (int i = first; i < last; i++) begin
			if (s_mid[i] == m) begin
				run_transfer(i, 1'b1);
			end
		end
	endtask

	// Round-robin model picks the next requester above the last winner and wraps around
	task automatic build_expected_order(input int first, input int last);
		int left [N_MASTERS];
		int cur;
		for (int m = 0; m < N_MASTERS; m++) begin
			left[m] = 0;
		end
		for (int i = first; i < last; i++) begin
			left[s_mid[i]]++;
		end
		exp_order.delete();
		cur = last_winner;
		for (int n = 0; n < last - first; n++) begin
			cur = (cur + 1) % N_MASTERS;
			for (int k = 1; k < N_MASTERS && left[cur] == 0; k++) begin
				cur = (cur + 1) % N_MASTERS;
			end
			exp_order.push_back(master_id_t'(cur));
			left[cur]--;
		end
		last_winner = cur;
	endtask

	initial begin
		int i;
		int j;
		rstn <= 1'b0;
		for (int m = 0; m < N_MASTERS; m++) begin
			m_adr[m]   <= '0;
			m_dat_w[m] <= '0;
			m_sel[m]   <= '0;
		end
		m_we  <= '0;
		m_cyc <= '0;
		m_stb <= '0;
		n_checks   = 0;
		n_mismatch = 0;
		n_fail     = 0;
		// Reset clears the arbiter history so master 0 wins first
		last_winner = N_MASTERS - 1;
		load_stimulus();

		repeat (7) begin
			@(posedge clk);
			@(negedge clk);
			check_idle_outputs();
		end
		@(posedge clk);
		rstn <= 1'b1;
		repeat (2) begin
			@(negedge clk);
			check_idle_outputs();
		end

		i = 0;
		while (i < n_lines) begin
			if (s_tag[i] == "seq") begin
				run_transfer(i, 1'b0);
				if (s_ack[i]) begin
					last_winner = s_mid[i];
				end
				i++;
			end else begin
				// Consecutive lines with the same tag start together
				j = i;
				while (j < n_lines && s_tag[j] == s_tag[i]) begin
					j++;
				end
				build_expected_order(i, j);
				got_order.delete();
				fork
					run_master_lines(0, i, j);
					run_master_lines(1, i, j);
					run_master_lines(2, i, j);
					run_master_lines(3, i, j);
				join
				if (got_order.size() != exp_order.size()) begin
					n_fail++;
					$display("group at entry %0d completed %0d transfers instead of %0d",
						i, got_order.size(), exp_order.size());
				end
				for (int k = 0; k < exp_order.size() && k < got_order.size(); k++) begin
					check_order(got_order[k], exp_order[k], k);
				end
				i = j;
			end
		end

		$display("checks %0d, mismatches %0d, other failures %0d", n_checks, n_mismatch, n_fail);
		if (n_mismatch == 0 && n_fail == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// File: tb/wb_stimulus.txt
# tag master we addr wdata sel resp rdata (hex values, resp is ack or err)
# seq lines run alone, consecutive par or rr lines start on all masters together
seq 0 1 00000000 11223344 f ack 00000000
seq 1 1 00000004 aabbccdd f ack 00000000
seq 0 1 00000000 0000ee00 2 ack 00000000
seq 2 1 00000004 99000000 8 ack 00000000
seq 3 1 00000004 00000077 1 ack 00000000
seq 1 0 00000000 00000000 f ack 1122ee44
seq 2 0 00000004 00000000 f ack 99bbcc77
seq 3 1 00000010 cafef00d f ack 00000000
seq 0 0 00002000 00000000 f err 00000000
seq 1 1 00001010 deadbeef f err 00000000
seq 2 0 00000010 00000000 f ack cafef00d
par 0 1 00000100 a0a0a0a0 f ack 00000000
par 1 1 00000104 b1b1b1b1 f ack 00000000
par 2 1 00000108 c2c2c2c2 f ack 00000000
par 3 1 0000010c d3d3d3d3 f ack 00000000
seq 2 0 00000100 00000000 f ack a0a0a0a0
seq 2 0 00000104 00000000 f ack b1b1b1b1
seq 2 0 00000108 00000000 f ack c2c2c2c2
seq 2 0 0000010c 00000000 f ack d3d3d3d3
rr 0 1 00000200 10000000 f ack 00000000
rr 1 1 00000204 21000000 f ack 00000000
rr 2 1 00000208 32000000 f ack 00000000
rr 3 1 0000020c 43000000 f ack 00000000
rr 0 0 00000200 00000000 f ack 10000000
rr 1 0 00000204 00000000 f ack 21000000
rr 2 0 00000208 00000000 f ack 32000000
rr 3 0 0000020c 00000000 f ack 43000000

// File: files.f
common/wb_pkg.sv
common/wb_if.sv
wb_interconnect/wb_rr_arbiter.sv
wb_interconnect/wb_interconnect_4x1.sv
hdl/wb_sram_slave.sv
hdl/wb_subsystem_top.sv
tb/tb_wb_subsystem.sv

// File: Bender.yml
package:
  name: wb_subsystem

sources:
  - common/wb_pkg.sv
  - common/wb_if.sv
  - wb_interconnect/wb_rr_arbiter.sv
  - wb_interconnect/wb_interconnect_4x1.sv
  - hdl/wb_sram_slave.sv
  - hdl/wb_subsystem_top.sv
  - target: test
    files:
      - tb/tb_wb_subsystem.sv
